// File: bench/inst_enc.svh
`ifndef INST_ENC_SVH
`define INST_ENC_SVH

// Shift-immediates also use this layout, with shamt in the rs2 field
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
  r_word = {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
  i_word = {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  s_word = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

// Bit 0 of the offset is dropped
function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  b_word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
  u_word = {imm, rd, opc};
endfunction

function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
  j_word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

`endif

// File: bench/tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top import rv_decode_pkg::*; ();

  localparam int N_LOW  = 8;
  localparam int N_ALU  = 40;
  localparam int N_MEM  = 20;
  localparam int N_CTRL = 10;
  localparam int N_BAD  = 30;
  localparam int N_TOTAL = N_LOW + 2 * N_ALU + 2 * N_MEM + 7 * N_CTRL + N_BAD + N_CTRL;
  // Reset cycles, one cycle per instruction, then some slack
  localparam int RUN_NS = (N_TOTAL + 3) * 4 + 100;

  typedef struct packed {
    logic              valid;
    logic              rena1;
    logic              rena2;
    logic [REG_AW-1:0] raddr1;
    logic [REG_AW-1:0] raddr2;
    logic              wena;
    logic [REG_AW-1:0] waddr;
    alu_op_e           alu_op;
    logic [XLEN-1:0]   operand1;
    logic [XLEN-1:0]   operand2;
    tran_op_e          tran_op;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   imm;
    logic              rmem_ena;
    logic              wmem_ena;
    logic [XLEN-1:0]   wmem_data;
    logic              wsel;
    logic              illegal;
  } exp_t;

  `include "inst_enc.svh"

  logic              clk;
  logic              rst_n_i;
  logic              valid_i;
  rv_inst_u          inst_i;
  logic [XLEN-1:0]   pc_i;
  logic [XLEN-1:0]   data1_i;
  logic [XLEN-1:0]   data2_i;
  logic              valid_o;
  logic              rena1_o;
  logic              rena2_o;
  logic [REG_AW-1:0] raddr1_o;
  logic [REG_AW-1:0] raddr2_o;
  logic              wena_o;
  logic [REG_AW-1:0] waddr_o;
  alu_op_e           alu_op_o;
  logic [XLEN-1:0]   operand1_o;
  logic [XLEN-1:0]   operand2_o;
  tran_op_e          tran_op_o;
  logic [XLEN-1:0]   pc_o;
  logic [XLEN-1:0]   imm_o;
  logic              rmem_ena_o;
  logic              wmem_ena_o;
  logic [XLEN-1:0]   wmem_data_o;
  logic              wsel_o;
  logic              illegal_o;

  integer seed = 32'h2ed02edb;
  int     n_checks = 0;
  int     n_errors = 0;
  logic   checking = 1'b0;
  exp_t   pend_exp;
  exp_t   cur_exp;
  string  pend_name;
  string  cur_name;

  decode_top u_dut (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  function automatic logic known_opcode(input logic [6:0] opc);
    return opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LOAD || opc == OPC_STORE ||
           opc == OPC_BRANCH || opc == OPC_JAL || opc == OPC_JALR || opc == OPC_LUI ||
           opc == OPC_AUIPC;
  endfunction

  function automatic alu_op_e int_alu_op(input logic [2:0] f3, input logic alt,
                                         input logic is_imm);
    case (f3)
      3'd0:    int_alu_op = (alt && !is_imm) ? ALU_SUB : ALU_ADD;
      3'd1:    int_alu_op = ALU_SLL;
      3'd2:    int_alu_op = is_imm ? ALU_SLTI : ALU_SLT;
      3'd3:    int_alu_op = is_imm ? ALU_SLTIU : ALU_SLTU;
      3'd4:    int_alu_op = ALU_XOR;
      3'd5:    int_alu_op = alt ? ALU_SRA : ALU_SRL;
      3'd6:    int_alu_op = ALU_OR;
      default: int_alu_op = ALU_AND;
    endcase
  endfunction

  // Reference decode of one word, straight from the RV32I field positions
  function automatic exp_t expected_decode(input logic [31:0] w, input logic v,
                                           input logic [31:0] pc, input logic [31:0] d1,
                                           input logic [31:0] d2);
    exp_t        e;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        ok;
    logic [31:0] imm_i;
    e = '0;
    ok = 1'b1;
    f3 = w[14:12];
    f7 = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    case (w[6:0])
      OPC_OP: begin
        ok = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        e.alu_op = int_alu_op(f3, f7[5], 1'b0);
        {e.rena1, e.rena2, e.wena} = 3'b111;
        e.operand1 = d1;
        e.operand2 = d2;
      end
      OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          ok = (f7 == F7_BASE);
        end else if (f3 == 3'd5) begin
          ok = (f7 == F7_BASE || f7 == F7_ALT);
        end
        e.alu_op = int_alu_op(f3, f7[5], 1'b1);
        {e.rena1, e.wena} = 2'b11;
        e.imm = imm_i;
        e.operand1 = d1;
        e.operand2 = imm_i;
      end
      OPC_LOAD: begin
        case (f3)
          3'd0:    e.alu_op = ALU_LB;
          3'd1:    e.alu_op = ALU_LH;
          3'd2:    e.alu_op = ALU_LW;
          3'd4:    e.alu_op = ALU_LBU;
          3'd5:    e.alu_op = ALU_LHU;
          default: ok = 1'b0;
        endcase
        {e.rena1, e.wena, e.rmem_ena, e.wsel} = 4'b1111;
        e.imm = imm_i;
        e.operand1 = d1;
        e.operand2 = imm_i;
      end
      OPC_STORE: begin
        ok = (f3 < 3'd3);
        e.alu_op = (f3 == 3'd0) ? ALU_SB : (f3 == 3'd1) ? ALU_SH : ALU_SW;
        {e.rena1, e.rena2, e.wmem_ena} = 3'b111;
        e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        e.operand1 = d1;
        e.operand2 = e.imm;
        e.wmem_data = d2;
      end
      OPC_BRANCH: begin
        ok = (f3 != 3'd2 && f3 != 3'd3);
        case (f3)
          3'd0:    e.tran_op = TRAN_BEQ;
          3'd1:    e.tran_op = TRAN_BNE;
          3'd4:    e.tran_op = TRAN_BLT;
          3'd5:    e.tran_op = TRAN_BGE;
          3'd6:    e.tran_op = TRAN_BLTU;
          default: e.tran_op = TRAN_BGEU;
        endcase
        {e.rena1, e.rena2} = 2'b11;
        e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        e.operand1 = d1;
        e.operand2 = d2;
      end
      OPC_JAL: begin
        e.alu_op = ALU_JUMP;
        e.tran_op = TRAN_JAL;
        e.wena = 1'b1;
        e.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e.operand2 = pc;
      end
      OPC_JALR: begin
        ok = (f3 == 3'd0);
        e.alu_op = ALU_JUMP;
        e.tran_op = TRAN_JALR;
        {e.rena1, e.wena} = 2'b11;
        e.imm = imm_i;
        e.operand1 = d1;
        e.operand2 = pc;
      end
      OPC_LUI, OPC_AUIPC: begin
        e.alu_op = ALU_ADD;
        e.wena = 1'b1;
        e.imm = {w[31:12], 12'h000};
        e.operand1 = (w[6:0] == OPC_AUIPC) ? pc : 32'h0;
        e.operand2 = e.imm;
      end
      default: ok = 1'b0;
    endcase
    if (!ok) begin
      e = '0;
    end
    e.illegal = !ok;
    e.pc = pc;
    // Bubble keeps data fields, drops all control
    if (!v) begin
      {e.rena1, e.rena2, e.wena, e.rmem_ena, e.wmem_ena, e.wsel, e.illegal} = '0;
      e.alu_op = ALU_NOP;
      e.tran_op = TRAN_NOP;
    end
    e.valid = v;
    e.raddr1 = e.rena1 ? w[19:15] : ZERO_REG;
    e.raddr2 = e.rena2 ? w[24:20] : ZERO_REG;
    e.waddr = e.wena ? w[11:7] : ZERO_REG;
    return e;
  endfunction

  task automatic issue(input string name, input logic [31:0] word, input logic v);
    logic [31:0] pc;
    logic [31:0] d1;
    logic [31:0] d2;
    pc = next_rand() & 32'hffff_fffc;
    d1 = next_rand();
    d2 = next_rand();
    valid_i   <= v;
    inst_i    <= word;
    pc_i      <= pc;
    data1_i   <= d1;
    data2_i   <= d2;
    pend_exp  <= expected_decode(word, v, pc, d1, d2);
    pend_name <= name;
    @(posedge clk);
  endtask

  task automatic compare_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    n_checks++;
    assert (act_v === exp_v) else begin
      n_errors++;
      $display("[ERROR] %s %s: expected %h actual %h", cur_name, field, exp_v, act_v);
    end
  endtask

  // Expectation follows the DUT register by one edge
  always @(posedge clk) begin
    checking <= 1'b1;
    if (!rst_n_i) begin
      cur_exp  <= '0;
      cur_name <= "reset";
    end else begin
      cur_exp  <= pend_exp;
      cur_name <= pend_name;
    end
  end

  always @(negedge clk) begin
    if (checking) begin
      compare_field("valid_o", cur_exp.valid, valid_o);
      compare_field("rena1_o", cur_exp.rena1, rena1_o);
      compare_field("rena2_o", cur_exp.rena2, rena2_o);
      compare_field("raddr1_o", cur_exp.raddr1, raddr1_o);
      compare_field("raddr2_o", cur_exp.raddr2, raddr2_o);
      compare_field("wena_o", cur_exp.wena, wena_o);
      compare_field("waddr_o", cur_exp.waddr, waddr_o);
      compare_field("alu_op_o", cur_exp.alu_op, alu_op_o);
      compare_field("operand1_o", cur_exp.operand1, operand1_o);
      compare_field("operand2_o", cur_exp.operand2, operand2_o);
      compare_field("tran_op_o", cur_exp.tran_op, tran_op_o);
      compare_field("pc_o", cur_exp.pc, pc_o);
      compare_field("imm_o", cur_exp.imm, imm_o);
      compare_field("rmem_ena_o", cur_exp.rmem_ena, rmem_ena_o);
      compare_field("wmem_ena_o", cur_exp.wmem_ena, wmem_ena_o);
      compare_field("wmem_data_o", cur_exp.wmem_data, wmem_data_o);
      compare_field("wsel_o", cur_exp.wsel, wsel_o);
      compare_field("illegal_o", cur_exp.illegal, illegal_o);
    end
  end

  initial begin
    #(RUN_NS);
    $display("Timeout: decode run did not finish within %0d ns", RUN_NS);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [11:0] imm12;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [2:0]  ld_f3 [0:4];
    logic [2:0]  br_f3 [0:5];
    ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // A valid add is presented during reset and must stay masked
    rst_n_i <= 1'b0;
    valid_i <= 1'b1;
    inst_i  <= r_word(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd3, OPC_OP);
    pc_i    <= 32'h0000_0100;
    data1_i <= 32'h1234_5678;
    data2_i <= 32'h9abc_def0;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    for (int i = 0; i < N_LOW; i++) begin
      issue("valid_low", next_rand(), 1'b0);
    end
    for (int i = 0; i < N_ALU; i++) begin
      r = next_rand();
      f7 = ((r[2:0] == 3'd0 || r[2:0] == 3'd5) && r[3]) ? F7_ALT : F7_BASE;
      issue("r_type", r_word(f7, r[8:4], r[13:9], r[2:0], r[18:14], OPC_OP), 1'b1);
    end
    for (int i = 0; i < N_ALU; i++) begin
      r = next_rand();
      imm12 = r[31:20];
      if (r[2:0] == F3_SLL) begin
        imm12[11:5] = F7_BASE;
      end else if (r[2:0] == F3_SRL_SRA) begin
        imm12[11:5] = r[3] ? F7_ALT : F7_BASE;
      end
      issue("op_imm", i_word(imm12, r[8:4], r[2:0], r[13:9], OPC_OP_IMM), 1'b1);
    end
    for (int i = 0; i < N_MEM; i++) begin
      r = next_rand();
      issue("load", i_word(r[31:20], r[12:8], ld_f3[r[7:0] % 5], r[17:13], OPC_LOAD), 1'b1);
    end
    for (int i = 0; i < N_MEM; i++) begin
      r = next_rand();
      issue("store", s_word(r[31:20], r[17:13], r[12:8], r[7:0] % 3), 1'b1);
    end
    for (int i = 0; i < 3 * N_CTRL; i++) begin
      r = next_rand();
      issue("branch", b_word(r[31:19], r[17:13], r[12:8], br_f3[r[7:0] % 6]), 1'b1);
    end
    for (int i = 0; i < N_CTRL; i++) begin
      r = next_rand();
      issue("jal", j_word(r[31:11], r[9:5]), 1'b1);
      r = next_rand();
      issue("jalr", i_word(r[31:20], r[8:4], F3_JALR, r[13:9], OPC_JALR), 1'b1);
      r = next_rand();
      issue("lui", u_word(r[31:12], r[8:4], OPC_LUI), 1'b1);
      r = next_rand();
      issue("auipc", u_word(r[31:12], r[8:4], OPC_AUIPC), 1'b1);
    end
    for (int i = 0; i < N_BAD; i++) begin
      r = next_rand();
      while (known_opcode(r[6:0])) begin
        r = next_rand();
      end
      issue("bad_opcode", r, 1'b1);
    end
    for (int i = 0; i < N_CTRL; i++) begin
      r = next_rand();
      f3 = r[0] ? F3_SLL : F3_SRL_SRA;
      f7 = r[31:25];
      // Flip bit 25 so funct7 is neither 0x00 nor 0x20
      if (f7 == F7_BASE || f7 == F7_ALT) begin
        f7 = f7 ^ 7'h01;
      end
      issue("bad_shift", r_word(f7, r[24:20], r[19:15], f3, r[11:7], OPC_OP_IMM), 1'b1);
    end
    @(negedge clk);
    @(posedge clk);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/decode_reg.sv
`timescale 1ns/1ps
`default_nettype none

module decode_reg import rv_decode_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  logic              rena1_i,
  input  logic              rena2_i,
  input  logic [REG_AW-1:0] raddr1_i,
  input  logic [REG_AW-1:0] raddr2_i,
  input  logic              wena_i,
  input  logic [REG_AW-1:0] waddr_i,
  input  alu_op_e           alu_op_i,
  input  logic [XLEN-1:0]   operand1_i,
  input  logic [XLEN-1:0]   operand2_i,
  input  tran_op_e          tran_op_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   imm_i,
  input  logic              rmem_ena_i,
  input  logic              wmem_ena_i,
  input  logic [XLEN-1:0]   wmem_data_i,
  input  logic              wsel_i,
  input  logic              illegal_i,
  output logic              valid_o,
  output logic              rena1_o,
  output logic              rena2_o,
  output logic [REG_AW-1:0] raddr1_o,
  output logic [REG_AW-1:0] raddr2_o,
  output logic              wena_o,
  output logic [REG_AW-1:0] waddr_o,
  output alu_op_e           alu_op_o,
  output logic [XLEN-1:0]   operand1_o,
  output logic [XLEN-1:0]   operand2_o,
  output tran_op_e          tran_op_o,
  output logic [XLEN-1:0]   pc_o,
  output logic [XLEN-1:0]   imm_o,
  output logic              rmem_ena_o,
  output logic              wmem_ena_o,
  output logic [XLEN-1:0]   wmem_data_o,
  output logic              wsel_o,
  output logic              illegal_o
);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o     <= 1'b0;
      rena1_o     <= 1'b0;
      rena2_o     <= 1'b0;
      wena_o      <= 1'b0;
      raddr1_o    <= ZERO_REG;
      raddr2_o    <= ZERO_REG;
      waddr_o     <= ZERO_REG;
      alu_op_o    <= ALU_NOP;
      tran_op_o   <= TRAN_NOP;
      rmem_ena_o  <= 1'b0;
      wmem_ena_o  <= 1'b0;
      wsel_o      <= 1'b0;
      illegal_o   <= 1'b0;
      operand1_o  <= '0;
      operand2_o  <= '0;
      pc_o        <= '0;
      imm_o       <= '0;
      wmem_data_o <= '0;
    end else begin
      // Bubble when no instruction is presented
      valid_o     <= valid_i;
      rena1_o     <= valid_i & rena1_i;
      rena2_o     <= valid_i & rena2_i;
      wena_o      <= valid_i & wena_i;
      raddr1_o    <= valid_i ? raddr1_i : ZERO_REG;
      raddr2_o    <= valid_i ? raddr2_i : ZERO_REG;
      waddr_o     <= valid_i ? waddr_i : ZERO_REG;
      alu_op_o    <= valid_i ? alu_op_i : ALU_NOP;
      tran_op_o   <= valid_i ? tran_op_i : TRAN_NOP;
      rmem_ena_o  <= valid_i & rmem_ena_i;
      wmem_ena_o  <= valid_i & wmem_ena_i;
      wsel_o      <= valid_i & wsel_i;
      illegal_o   <= valid_i & illegal_i;
      operand1_o  <= operand1_i;
      operand2_o  <= operand2_i;
      pc_o        <= pc_i;
      imm_o       <= imm_i;
      wmem_data_o <= wmem_data_i;
    end
  end

endmodule

`default_nettype wire

// File: design/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top import rv_decode_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  rv_inst_u          inst_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   data1_i,
  input  logic [XLEN-1:0]   data2_i,
  output logic              valid_o,
  output logic              rena1_o,
  output logic              rena2_o,
  output logic [REG_AW-1:0] raddr1_o,
  output logic [REG_AW-1:0] raddr2_o,
  output logic              wena_o,
  output logic [REG_AW-1:0] waddr_o,
  output alu_op_e           alu_op_o,
  output logic [XLEN-1:0]   operand1_o,
  output logic [XLEN-1:0]   operand2_o,
  output tran_op_e          tran_op_o,
  output logic [XLEN-1:0]   pc_o,
  output logic [XLEN-1:0]   imm_o,
  output logic              rmem_ena_o,
  output logic              wmem_ena_o,
  output logic [XLEN-1:0]   wmem_data_o,
  output logic              wsel_o,
  output logic              illegal_o
);

  alu_op_e           alu_op;
  tran_op_e          tran_op;
  imm_fmt_e          imm_fmt;
  op1_sel_e          op1_sel;
  op2_sel_e          op2_sel;
  logic              rena1;
  logic              rena2;
  logic              wena;
  logic [REG_AW-1:0] raddr1;
  logic [REG_AW-1:0] raddr2;
  logic [REG_AW-1:0] waddr;
  logic              rmem_ena;
  logic              wmem_ena;
  logic              wsel;
  logic              illegal;
  logic [XLEN-1:0]   imm;
  logic [XLEN-1:0]   operand1;
  logic [XLEN-1:0]   operand2;
  logic [XLEN-1:0]   wmem_data;

  inst_classifier u_classifier (
    .inst_i     (inst_i),
    .alu_op_o   (alu_op),
    .tran_op_o  (tran_op),
    .imm_fmt_o  (imm_fmt),
    .op1_sel_o  (op1_sel),
    .op2_sel_o  (op2_sel),
    .rena1_o    (rena1),
    .rena2_o    (rena2),
    .wena_o     (wena),
    .raddr1_o   (raddr1),
    .raddr2_o   (raddr2),
    .waddr_o    (waddr),
    .rmem_ena_o (rmem_ena),
    .wmem_ena_o (wmem_ena),
    .wsel_o     (wsel),
    .illegal_o  (illegal)
  );

  imm_gen u_imm_gen (
    .inst_i    (inst_i),
    .imm_fmt_i (imm_fmt),
    .imm_o     (imm)
  );

  operand_mux u_operand_mux (
    .op1_sel_i   (op1_sel),
    .op2_sel_i   (op2_sel),
    .wmem_ena_i  (wmem_ena),
    .data1_i     (data1_i),
    .data2_i     (data2_i),
    .pc_i        (pc_i),
    .imm_i       (imm),
    .operand1_o  (operand1),
    .operand2_o  (operand2),
    .wmem_data_o (wmem_data)
  );

  decode_reg u_decode_reg (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .rena1_i     (rena1),
    .rena2_i     (rena2),
    .raddr1_i    (raddr1),
    .raddr2_i    (raddr2),
    .wena_i      (wena),
    .waddr_i     (waddr),
    .alu_op_i    (alu_op),
    .operand1_i  (operand1),
    .operand2_i  (operand2),
    .tran_op_i   (tran_op),
    .pc_i        (pc_i),
    .imm_i       (imm),
    .rmem_ena_i  (rmem_ena),
    .wmem_ena_i  (wmem_ena),
    .wmem_data_i (wmem_data),
    .wsel_i      (wsel),
    .illegal_i   (illegal),
    .valid_o     (valid_o),
    .rena1_o     (rena1_o),
    .rena2_o     (rena2_o),
    .raddr1_o    (raddr1_o),
    .raddr2_o    (raddr2_o),
    .wena_o      (wena_o),
    .waddr_o     (waddr_o),
    .alu_op_o    (alu_op_o),
    .operand1_o  (operand1_o),
    .operand2_o  (operand2_o),
    .tran_op_o   (tran_op_o),
    .pc_o        (pc_o),
    .imm_o       (imm_o),
    .rmem_ena_o  (rmem_ena_o),
    .wmem_ena_o  (wmem_ena_o),
    .wmem_data_o (wmem_data_o),
    .wsel_o      (wsel_o),
    .illegal_o   (illegal_o)
  );

endmodule

`default_nettype wire

// File: design/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen import rv_decode_pkg::*; (
  input  rv_inst_u          inst_i,
  input  imm_fmt_e          imm_fmt_i,
  output logic [XLEN-1:0]   imm_o
);

  always_comb begin
    case (imm_fmt_i)
      IMM_I: begin
        imm_o = {{20{inst_i.i_fmt.imm_11_0[11]}}, inst_i.i_fmt.imm_11_0};
      end
      IMM_S: begin
        imm_o = {{20{inst_i.s_fmt.imm_11_5[6]}}, inst_i.s_fmt.imm_11_5,
                 inst_i.s_fmt.imm_4_0};
      end
      IMM_B: begin
        imm_o = {{19{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_12,
                 inst_i.b_fmt.imm_11, inst_i.b_fmt.imm_10_5,
                 inst_i.b_fmt.imm_4_1, 1'b0};
      end
      IMM_U: begin
        // Upper 20 bits, low 12 zero filled
        imm_o = {inst_i.u_fmt.imm_31_12, 12'b0};
      end
      IMM_J: begin
        imm_o = {{11{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_20,
                 inst_i.j_fmt.imm_19_12, inst_i.j_fmt.imm_11,
                 inst_i.j_fmt.imm_10_1, 1'b0};
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/inst_classifier.sv
`timescale 1ns/1ps
`default_nettype none

module inst_classifier import rv_decode_pkg::*; (
  input  rv_inst_u          inst_i,
  output alu_op_e           alu_op_o,
  output tran_op_e          tran_op_o,
  output imm_fmt_e          imm_fmt_o,
  output op1_sel_e          op1_sel_o,
  output op2_sel_e          op2_sel_o,
  output logic              rena1_o,
  output logic              rena2_o,
  output logic              wena_o,
  output logic [REG_AW-1:0] raddr1_o,
  output logic [REG_AW-1:0] raddr2_o,
  output logic [REG_AW-1:0] waddr_o,
  output logic              rmem_ena_o,
  output logic              wmem_ena_o,
  output logic              wsel_o,
  output logic              illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       known;
  logic       alt_ok;

  assign opcode = inst_i.r_fmt.opcode;
  assign funct3 = inst_i.r_fmt.funct3;
  assign funct7 = inst_i.r_fmt.funct7;

  // funct7 = 0x20 is only defined for sub and sra/srai
  assign alt_ok = (funct7 == F7_BASE) ||
                  ((funct7 == F7_ALT) && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));

  always_comb begin
    known      = 1'b0;
    alu_op_o   = ALU_NOP;
    tran_op_o  = TRAN_NOP;
    imm_fmt_o  = IMM_NONE;
    op1_sel_o  = OP1_ZERO;
    op2_sel_o  = OP2_ZERO;
    rena1_o    = 1'b0;
    rena2_o    = 1'b0;
    wena_o     = 1'b0;
    rmem_ena_o = 1'b0;
    wmem_ena_o = 1'b0;
    wsel_o     = 1'b0;
    case (opcode)
      OPC_OP: begin
        known = alt_ok;
        case (funct3)
          F3_ADD_SUB: alu_op_o = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op_o = ALU_SLL;
          F3_SLT:     alu_op_o = ALU_SLT;
          F3_SLTU:    alu_op_o = ALU_SLTU;
          F3_XOR:     alu_op_o = ALU_XOR;
          F3_SRL_SRA: alu_op_o = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op_o = ALU_OR;
          default:    alu_op_o = ALU_AND;
        endcase
        {rena1_o, rena2_o, wena_o} = 3'b111;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_RS2;
      end
      OPC_OP_IMM: begin
        // Only the shifts carry funct7 in the immediate
        known = (funct3 == F3_SLL) ? (funct7 == F7_BASE) :
                (funct3 == F3_SRL_SRA) ? alt_ok : 1'b1;
        case (funct3)
          F3_ADD_SUB: alu_op_o = ALU_ADD;
          F3_SLL:     alu_op_o = ALU_SLL;
          F3_SLT:     alu_op_o = ALU_SLTI;
          F3_SLTU:    alu_op_o = ALU_SLTIU;
          F3_XOR:     alu_op_o = ALU_XOR;
          F3_SRL_SRA: alu_op_o = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op_o = ALU_OR;
          default:    alu_op_o = ALU_AND;
        endcase
        {rena1_o, wena_o} = 2'b11;
        imm_fmt_o = IMM_I;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_IMM;
      end
      OPC_LOAD: begin
        known = 1'b1;
        case (funct3)
          F3_LB:   alu_op_o = ALU_LB;
          F3_LH:   alu_op_o = ALU_LH;
          F3_LW:   alu_op_o = ALU_LW;
          F3_LBU:  alu_op_o = ALU_LBU;
          F3_LHU:  alu_op_o = ALU_LHU;
          default: known = 1'b0;
        endcase
        {rena1_o, wena_o, rmem_ena_o, wsel_o} = 4'b1111;
        imm_fmt_o = IMM_I;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_IMM;
      end
      OPC_STORE: begin
        known = 1'b1;
        case (funct3)
          F3_SB:   alu_op_o = ALU_SB;
          F3_SH:   alu_op_o = ALU_SH;
          F3_SW:   alu_op_o = ALU_SW;
          default: known = 1'b0;
        endcase
        {rena1_o, rena2_o, wmem_ena_o} = 3'b111;
        imm_fmt_o = IMM_S;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_IMM;
      end
      OPC_BRANCH: begin
        known = 1'b1;
        case (funct3)
          F3_BEQ:  tran_op_o = TRAN_BEQ;
          F3_BNE:  tran_op_o = TRAN_BNE;
          F3_BLT:  tran_op_o = TRAN_BLT;
          F3_BGE:  tran_op_o = TRAN_BGE;
          F3_BLTU: tran_op_o = TRAN_BLTU;
          F3_BGEU: tran_op_o = TRAN_BGEU;
          default: known = 1'b0;
        endcase
        {rena1_o, rena2_o} = 2'b11;
        imm_fmt_o = IMM_B;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_RS2;
      end
      OPC_JAL: begin
        known     = 1'b1;
        alu_op_o  = ALU_JUMP;
        tran_op_o = TRAN_JAL;
        wena_o    = 1'b1;
        imm_fmt_o = IMM_J;
        op2_sel_o = OP2_PC;
      end
      OPC_JALR: begin
        known     = (funct3 == F3_JALR);
        alu_op_o  = ALU_JUMP;
        tran_op_o = TRAN_JALR;
        {rena1_o, wena_o} = 2'b11;
        imm_fmt_o = IMM_I;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_PC;
      end
      OPC_LUI, OPC_AUIPC: begin
        known     = 1'b1;
        alu_op_o  = ALU_ADD;
        wena_o    = 1'b1;
        imm_fmt_o = IMM_U;
        op1_sel_o = (opcode == OPC_AUIPC) ? OP1_PC : OP1_ZERO;
        op2_sel_o = OP2_IMM;
      end
      default: known = 1'b0;
    endcase
    // Unknown word becomes a bubble
    if (!known) begin
      alu_op_o   = ALU_NOP;
      tran_op_o  = TRAN_NOP;
      imm_fmt_o  = IMM_NONE;
      op1_sel_o  = OP1_ZERO;
      op2_sel_o  = OP2_ZERO;
      {rena1_o, rena2_o, wena_o} = 3'b000;
      {rmem_ena_o, wmem_ena_o, wsel_o} = 3'b000;
    end
  end

  assign raddr1_o  = rena1_o ? inst_i.r_fmt.rs1 : ZERO_REG;
  assign raddr2_o  = rena2_o ? inst_i.r_fmt.rs2 : ZERO_REG;
  assign waddr_o   = wena_o  ? inst_i.r_fmt.rd  : ZERO_REG;
  assign illegal_o = !known;

endmodule

`default_nettype wire

// File: design/operand_mux.sv
`timescale 1ns/1ps
`default_nettype none

module operand_mux import rv_decode_pkg::*; (
  input  op1_sel_e          op1_sel_i,
  input  op2_sel_e          op2_sel_i,
  input  logic              wmem_ena_i,
  input  logic [XLEN-1:0]   data1_i,
  input  logic [XLEN-1:0]   data2_i,
  input  logic [XLEN-1:0]   pc_i,
  input  logic [XLEN-1:0]   imm_i,
  output logic [XLEN-1:0]   operand1_o,
  output logic [XLEN-1:0]   operand2_o,
  output logic [XLEN-1:0]   wmem_data_o
);

  always_comb begin
    case (op1_sel_i)
      OP1_RS1: operand1_o = data1_i;
      OP1_PC:  operand1_o = pc_i;
      default: operand1_o = '0;
    endcase
  end

  // Jumps carry pc on operand 2 for the link value
  always_comb begin
    case (op2_sel_i)
      OP2_RS2: operand2_o = data2_i;
      OP2_IMM: operand2_o = imm_i;
      OP2_PC:  operand2_o = pc_i;
      default: operand2_o = '0;
    endcase
  end

  assign wmem_data_o = wmem_ena_i ? data2_i : '0;

endmodule

`default_nettype wire

// File: design/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  localparam logic [REG_AW-1:0] ZERO_REG = 5'd0;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // Integer ops, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Loads and stores
  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;
  localparam logic [2:0] F3_SW  = 3'b010;

  // Branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [2:0] F3_JALR = 3'b000;

  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;

  typedef enum logic [4:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_SLTI, ALU_SLTIU,
    ALU_SB, ALU_SH, ALU_SW,
    ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
    ALU_JUMP
  } alu_op_e;

  typedef enum logic [3:0] {
    TRAN_NOP, TRAN_BEQ, TRAN_BNE, TRAN_BLT, TRAN_BGE,
    TRAN_BLTU, TRAN_BGEU, TRAN_JAL, TRAN_JALR
  } tran_op_e;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_fmt_e;

  typedef enum logic [1:0] {
    OP1_ZERO, OP1_RS1, OP1_PC
  } op1_sel_e;

  typedef enum logic [1:0] {
    OP2_ZERO, OP2_RS2, OP2_IMM, OP2_PC
  } op2_sel_e;

  // Same 32-bit word seen through each base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } rv_inst_u;

endpackage

`default_nettype wire

// File: sources.f
+incdir+bench
design/rv_decode_pkg.sv
design/inst_classifier.sv
design/imm_gen.sv
design/operand_mux.sv
design/decode_reg.sv
design/decode_top.sv
bench/tb_decode_top.sv
